// File: Makefile
# Verilator build and run of the glue testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_minimig_glue \
		-f filelist.f -Mdir obj_dir
	./obj_dir/Vtb_minimig_glue

clean:
	rm -rf obj_dir

// File: filelist.f
hdl/glue_pkg.sv
hdl/line_event_detect.sv
hdl/reset_sequencer.sv
hdl/drive_sound.sv
hdl/status_indicators.sv
hdl/chipset_mode.sv
hdl/minimig_glue.sv
verification/tb_minimig_glue.sv

// File: hdl/chipset_mode.sv
// video standard latch and turbo / 15 kHz mode flags derived from the osd configuration words
`timescale 1ns/1ps

module chipset_mode (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   clk7_en_i,
	input  logic                   sys_reset_i,
	input  logic                   ovl_i,        // rom overlay at 0
	input  logic                   cpu_custom_i,
	input  logic                   scan15khz_i,
	input  logic                   vgaswitch_i,
	input  glue_pkg::chipset_cfg_t chipset_cfg_i,
	input  glue_pkg::cpu_cfg_t     cpu_cfg_i,
	input  glue_pkg::mem_cfg_t     mem_cfg_i,
	output logic                   ntsc_o,
	output logic                   turbochipram_o,
	output logic                   turbokick_o,
	output logic                   mode_15khz_o
);

	logic aga;      // enhanced chipset selected
	logic chip_2mb; // full chip ram fitted

	assign aga      = chipset_cfg_i[glue_pkg::CHIPSET_AGA_BIT];
	assign chip_2mb = mem_cfg_i[glue_pkg::MEM_CHIP_HI_BIT] & mem_cfg_i[glue_pkg::MEM_CHIP_LO_BIT];

	// pal/ntsc follows the osd only during reset, change needs a reboot
	always_ff @(posedge clk) begin
		if (reset)
			ntsc_o <= glue_pkg::NTSC_DEFAULT;
		else if (clk7_en_i && sys_reset_i)
			ntsc_o <= chipset_cfg_i[glue_pkg::CHIPSET_NTSC_BIT];
	end

	// --------------------------------------------------
	// turbo permissions
	// --------------------------------------------------
	// chip ram at cpu speed, needs aga, 2MB and the bus from agnus
	assign turbochipram_o = aga & ~ovl_i & cpu_cfg_i[glue_pkg::CPU_FASTCHIP_BIT]
		& cpu_custom_i & chip_2mb;

	// kick shadow, never while the overlay maps rom low
	assign turbokick_o = ~ovl_i & (cpu_cfg_i[glue_pkg::CPU_FASTKICK_BIT] | aga);

	assign mode_15khz_o = scan15khz_i ^ vgaswitch_i; // hotkey flips the jumper setting

endmodule

// File: hdl/drive_sound.sv
// floppy step click for the buzzer, each accepted step keeps the output on for 15 video lines
`timescale 1ns/1ps

module drive_sound (
	input  logic clk,
	input  logic reset,
	input  logic sys_reset_i,     // no clicks while the system boots
	input  logic step_pulse_i,
	input  logic sol_pulse_i,
	input  logic disk_change_n_i, // low = no disk
	output logic drv_snd_o
);

	glue_pkg::drv_cnt_t drv_cnt; // lines left in the click, 0 = idle
	logic               start;   // qualified step
	logic               advance; // line start during a click

	assign start   = (drv_cnt == '0) & step_pulse_i & disk_change_n_i & ~sys_reset_i;
	assign advance = (drv_cnt != '0) & sol_pulse_i;

	// --------------------------------------------------
	// line counter, wraps back to idle
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			drv_cnt   <= '0;
			drv_snd_o <= 1'b0;
		end else begin
			if (start || advance)
				drv_cnt <= drv_cnt + 1'b1; // steps mid-click fall through here
			drv_snd_o <= |drv_cnt;         // registered busy flag
		end
	end

endmodule

// File: hdl/glue_pkg.sv
// shared widths, config bit positions and defaults for the board glue logic, referenced as glue_pkg::name
package glue_pkg;

	// --------------------------------------------------
	// counters
	// --------------------------------------------------
	typedef logic [3:0] drv_cnt_t;   // step sound length in video lines
	typedef logic [3:0] led_cnt_t;   // power led pwm phase
	typedef logic [3:0] frame_cnt_t; // reset stretch in frames

	// --------------------------------------------------
	// configuration words from the osd side
	// --------------------------------------------------
	typedef logic [4:0] chipset_cfg_t;
	typedef logic [3:0] cpu_cfg_t;
	typedef logic [6:0] mem_cfg_t;

	// chipset word
	localparam int CHIPSET_NTSC_BIT = 1; // 1 = ntsc, 0 = pal
	localparam int CHIPSET_AGA_BIT  = 4; // enhanced chipset

	// cpu word
	localparam int CPU_FASTCHIP_BIT = 2; // fast chip ram access
	localparam int CPU_FASTKICK_BIT = 3; // kickstart shadowed in fast memory

	// memory word, both low bits set means 2MB chip
	localparam int MEM_CHIP_LO_BIT = 0;
	localparam int MEM_CHIP_HI_BIT = 1;

	// --------------------------------------------------
	// defaults
	// --------------------------------------------------
	// frame starts that reset is held after all requests are gone
	localparam frame_cnt_t RESET_FRAMES_DEFAULT = 4'd3;

	// video standard until the first latch, pal
	localparam logic NTSC_DEFAULT = 1'b0;

endpackage

// File: hdl/line_event_detect.sv
// edge detector for the step, line, frame and vsync levels, feeds single-cycle strobes to the glue blocks
`timescale 1ns/1ps

module line_event_detect (
	input  logic clk,
	input  logic clk7_en_i,
	input  logic step_n_i,
	input  logic sol_i,
	input  logic sof_i,
	input  logic vsync_n_i,
	output logic step_pulse_o, // step_n rising
	output logic sol_pulse_o,  // sol rising
	output logic sof_pulse_o,  // sof rising
	output logic vsync_fall_o  // vsync_n falling, 7 MHz qualified
);

	// --------------------------------------------------
	// delay flops
	// --------------------------------------------------
	logic step_del  = 1'b0;
	logic sol_del   = 1'b0;
	logic sof_del   = 1'b0;
	logic vsync_del = 1'b0; // low so no fall is seen before a high

	always_ff @(posedge clk) begin
		step_del <= step_n_i;
		sol_del  <= sol_i;
		sof_del  <= sof_i;
	end

	// vsync sampled at the chipset rate only
	always_ff @(posedge clk) begin
		if (clk7_en_i)
			vsync_del <= vsync_n_i;
	end

	// --------------------------------------------------
	// pulses
	// --------------------------------------------------
	assign step_pulse_o = step_n_i & ~step_del; // head step done
	assign sol_pulse_o  = sol_i & ~sol_del;
	assign sof_pulse_o  = sof_i & ~sof_del;

	// falling edge, only counts on an enable cycle
	assign vsync_fall_o = clk7_en_i & ~vsync_n_i & vsync_del;

endmodule

// File: hdl/minimig_glue.sv
// board-level glue of the home computer top: reset stretch, step buzzer, power led, mcu sync, mode flags
`timescale 1ns/1ps

module minimig_glue #(
	parameter glue_pkg::frame_cnt_t RESET_FRAMES = glue_pkg::RESET_FRAMES_DEFAULT
) (
	input  logic                    clk,
	input  logic                    reset,            // power-on reset
	input  logic                    clk7_en_i,        // 7 MHz enable
	input  logic                    rst_ext_i,        // reset from ctrl block
	input  logic                    kbd_rst_i,        // keyboard ctrl-a-a
	input  logic                    usr_rst_i,        // osd user reset
	input  logic                    cpu_reset_in_n_i, // cpu executed reset instr
	input  logic                    cpu_rst_i,        // cpu-only reset from host
	input  logic                    step_n_i,         // floppy step, active low
	input  logic                    sol_i,            // start of line
	input  logic                    sof_i,            // start of frame
	input  logic                    vsync_n_i,
	input  logic                    hsync_n_i,
	input  logic                    disk_change_n_i,  // high with a disk inserted
	input  logic                    led_n_i,          // led request from cia, low = on
	input  logic                    turbo_i,
	input  logic                    ovl_i,            // kickstart overlay
	input  logic                    cpu_custom_i,     // agnus grants chip bus to cpu
	input  logic                    scan15khz_i,
	input  logic                    vgaswitch_i,      // keyboard video toggle
	input  glue_pkg::chipset_cfg_t  chipset_cfg_i,
	input  glue_pkg::cpu_cfg_t      cpu_cfg_i,
	input  glue_pkg::mem_cfg_t      mem_cfg_i,
	output logic                    rst_o,
	output logic                    cpu_reset_n_o,
	output logic                    drv_snd_o,        // buzzer
	output logic                    pwrled_o,
	output logic                    init_b_o,         // vsync toggle for the mcu
	output logic                    ntsc_o,
	output logic                    turbochipram_o,
	output logic                    turbokick_o,
	output logic                    mode_15khz_o,
	output logic [5:0]              memcfg_o
);

	// --------------------------------------------------
	// internal strobes
	// --------------------------------------------------
	logic step_pulse;
	logic sol_pulse;
	logic sof_pulse;
	logic vsync_fall;
	logic sys_reset; // stretched system reset

	line_event_detect u_events (
		.clk          (clk),
		.clk7_en_i    (clk7_en_i),
		.step_n_i     (step_n_i),
		.sol_i        (sol_i),
		.sof_i        (sof_i),
		.vsync_n_i    (vsync_n_i),
		.step_pulse_o (step_pulse),
		.sol_pulse_o  (sol_pulse),
		.sof_pulse_o  (sof_pulse),
		.vsync_fall_o (vsync_fall)
	);

	reset_sequencer #(
		.RESET_FRAMES (RESET_FRAMES)
	) u_rst_seq (
		.clk              (clk),
		.reset            (reset),
		.rst_ext_i        (rst_ext_i),
		.kbd_rst_i        (kbd_rst_i),
		.usr_rst_i        (usr_rst_i),
		.cpu_reset_in_n_i (cpu_reset_in_n_i),
		.cpu_rst_i        (cpu_rst_i),
		.sof_pulse_i      (sof_pulse),
		.sys_reset_o      (sys_reset),
		.cpu_reset_n_o    (cpu_reset_n_o)
	);

	drive_sound u_drv_snd (
		.clk             (clk),
		.reset           (reset),
		.sys_reset_i     (sys_reset),
		.step_pulse_i    (step_pulse),
		.sol_pulse_i     (sol_pulse),
		.disk_change_n_i (disk_change_n_i),
		.drv_snd_o       (drv_snd_o)
	);

	status_indicators u_status (
		.clk          (clk),
		.reset        (reset),
		.hsync_n_i    (hsync_n_i),
		.led_n_i      (led_n_i),
		.turbo_i      (turbo_i),
		.vsync_fall_i (vsync_fall),
		.pwrled_o     (pwrled_o),
		.init_b_o     (init_b_o)
	);

	chipset_mode u_mode (
		.clk            (clk),
		.reset          (reset),
		.clk7_en_i      (clk7_en_i),
		.sys_reset_i    (sys_reset),
		.ovl_i          (ovl_i),
		.cpu_custom_i   (cpu_custom_i),
		.scan15khz_i    (scan15khz_i),
		.vgaswitch_i    (vgaswitch_i),
		.chipset_cfg_i  (chipset_cfg_i),
		.cpu_cfg_i      (cpu_cfg_i),
		.mem_cfg_i      (mem_cfg_i),
		.ntsc_o         (ntsc_o),
		.turbochipram_o (turbochipram_o),
		.turbokick_o    (turbokick_o),
		.mode_15khz_o   (mode_15khz_o)
	);

	assign rst_o    = sys_reset;       // reset status to the outside
	assign memcfg_o = mem_cfg_i[5:0];  // hrtmon bit stays internal

endmodule

// File: hdl/reset_sequencer.sv
// collects all reset requests, syncs them and holds system reset for RESET_FRAMES frame starts
`timescale 1ns/1ps

module reset_sequencer #(
	parameter glue_pkg::frame_cnt_t RESET_FRAMES = glue_pkg::RESET_FRAMES_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	input  logic rst_ext_i,
	input  logic kbd_rst_i,
	input  logic usr_rst_i,
	input  logic cpu_reset_in_n_i, // low while cpu drives its reset line
	input  logic cpu_rst_i,        // holds only the cpu
	input  logic sof_pulse_i,
	output logic sys_reset_o,
	output logic cpu_reset_n_o
);

	logic                 rst_req;   // merged request
	logic                 rst_meta;  // sync stage 1
	logic                 rst_sync;  // sync stage 2
	glue_pkg::frame_cnt_t frame_cnt; // frames since request cleared

	assign rst_req = reset | rst_ext_i | kbd_rst_i | usr_rst_i | ~cpu_reset_in_n_i;

	// two stage sync, comes up asserted
	always_ff @(posedge clk) begin
		if (reset) begin
			rst_meta <= 1'b1;
			rst_sync <= 1'b1;
		end else begin
			rst_meta <= rst_req;
			rst_sync <= rst_meta;
		end
	end

	// --------------------------------------------------
	// frame stretch
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || rst_sync) begin
			sys_reset_o <= 1'b1;   // hold and rearm
			frame_cnt   <= '0;
		end else if (sys_reset_o && sof_pulse_i) begin
			frame_cnt <= frame_cnt + 1'b1;
			// last frame, release at this edge
			if (frame_cnt == glue_pkg::frame_cnt_t'(RESET_FRAMES - 1'b1))
				sys_reset_o <= 1'b0;
		end
	end

	// cpu stays in reset with the system or on its own request
	assign cpu_reset_n_o = ~(sys_reset_o | cpu_rst_i);

endmodule

// File: hdl/status_indicators.sv
// power led dimming in turbo mode and the once-per-frame toggle that paces the mcu osd update
`timescale 1ns/1ps

module status_indicators (
	input  logic clk,
	input  logic reset,
	input  logic hsync_n_i,
	input  logic led_n_i,      // high = led off request
	input  logic turbo_i,
	input  logic vsync_fall_i,
	output logic pwrled_o,
	output logic init_b_o
);

	// --------------------------------------------------
	// led pwm
	// --------------------------------------------------
	glue_pkg::led_cnt_t led_cnt;
	logic               led_dim; // off for one step in 16

	// runs only while hsync is inactive
	always_ff @(posedge clk) begin
		if (reset) begin
			led_cnt <= '0;
			led_dim <= 1'b0;
		end else if (hsync_n_i) begin
			led_cnt <= led_cnt + 1'b1;
			led_dim <= |led_cnt;
		end
	end

	// off state glows dimly when turbo is on
	assign pwrled_o = ~(led_n_i & (led_dim | ~turbo_i));

	// --------------------------------------------------
	// mcu sync
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset)
			init_b_o <= 1'b0;
		else if (vsync_fall_i)
			init_b_o <= ~init_b_o; // one flip per frame
	end

endmodule

// File: verification/tb_minimig_glue.sv
// random-stimulus testbench for the glue top, every output checked each cycle against a cycle model
`timescale 1ns/1ps

module tb_minimig_glue;

	localparam glue_pkg::frame_cnt_t TB_RESET_FRAMES = 4'd4; // differs from the package default
	localparam int WAIT_LIMIT = 2000;                       // cycles per wait loop

	logic clk;
	logic reset;
	logic clk7_en_i;
	logic rst_ext_i, kbd_rst_i, usr_rst_i;  // reset sources
	logic cpu_reset_in_n_i, cpu_rst_i;
	logic step_n_i, sol_i, sof_i;
	logic vsync_n_i, hsync_n_i;
	logic disk_change_n_i, led_n_i, turbo_i;
	logic ovl_i, cpu_custom_i, scan15khz_i, vgaswitch_i;
	glue_pkg::chipset_cfg_t chipset_cfg_i;
	glue_pkg::cpu_cfg_t     cpu_cfg_i;
	glue_pkg::mem_cfg_t     mem_cfg_i;
	logic rst_o, cpu_reset_n_o, drv_snd_o, pwrled_o, init_b_o;
	logic ntsc_o, turbochipram_o, turbokick_o, mode_15khz_o;
	logic [5:0] memcfg_o;

	string test_name = "init";
	bit    checking  = 1'b0; // off until reset values are defined

	// --------------------------------------------------
	// model state
	// --------------------------------------------------
	logic m_step_del = 1'b0;
	logic m_sol_del  = 1'b0;
	logic m_sof_del  = 1'b0;
	logic m_vs_del   = 1'b0;
	logic m_meta, m_sync, m_sys;
	logic [3:0] m_fcnt;
	logic [3:0] m_dcnt; // lines of the current click
	logic m_snd;
	logic [3:0] m_lcnt;
	logic m_dim, m_initb, m_ntsc;

	minimig_glue #(.RESET_FRAMES(TB_RESET_FRAMES)) UUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin : model_step
		logic step_p;
		logic sol_p;
		logic sof_p;
		logic vs_fall;
		step_p  = step_n_i & ~m_step_del;
		sol_p   = sol_i & ~m_sol_del;
		sof_p   = sof_i & ~m_sof_del;
		vs_fall = clk7_en_i & ~vsync_n_i & m_vs_del; // vsync seen on enable cycles only
		m_step_del <= step_n_i;
		m_sol_del  <= sol_i;
		m_sof_del  <= sof_i;
		if (clk7_en_i)
			m_vs_del <= vsync_n_i;
		// request merge and two flop sync
		m_meta <= reset | rst_ext_i | kbd_rst_i | usr_rst_i | ~cpu_reset_in_n_i;
		m_sync <= reset | m_meta;
		if (reset || m_sync) begin
			m_sys  <= 1'b1;
			m_fcnt <= 4'd0;
		end else if (m_sys && sof_p) begin
			m_fcnt <= m_fcnt + 4'd1;
			if (m_fcnt + 4'd1 == TB_RESET_FRAMES)
				m_sys <= 1'b0; // count reached, release
		end
		if (reset) begin
			m_dcnt  <= 4'd0;
			m_snd   <= 1'b0;
			m_lcnt  <= 4'd0;
			m_dim   <= 1'b0;
			m_initb <= 1'b0;
			m_ntsc  <= glue_pkg::NTSC_DEFAULT;
		end else begin
			if (m_dcnt == 4'd0 && step_p && disk_change_n_i && !m_sys)
				m_dcnt <= 4'd1;
			else if (m_dcnt != 4'd0 && sol_p)
				m_dcnt <= (m_dcnt == 4'd15) ? 4'd0 : m_dcnt + 4'd1; // 15th line ends it
			m_snd <= (m_dcnt != 4'd0);
			if (hsync_n_i) begin
				m_lcnt <= m_lcnt + 4'd1;
				m_dim  <= (m_lcnt != 4'd0);
			end
			if (vs_fall)
				m_initb <= ~m_initb;
			if (clk7_en_i && m_sys)
				m_ntsc <= chipset_cfg_i[1]; // latched only in reset
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	task automatic compare_value(string what, logic [31:0] exp, logic [31:0] act);
		if (act !== exp) begin
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			$display("Done: errors found");
			$fatal(1, "output mismatch");
		end
	endtask

	task automatic check_outputs();
		compare_value("rst_o", m_sys, rst_o);
		compare_value("cpu_reset_n_o", !(m_sys || cpu_rst_i), cpu_reset_n_o);
		compare_value("drv_snd_o", m_snd, drv_snd_o);
		compare_value("pwrled_o", !(led_n_i && (m_dim || !turbo_i)), pwrled_o);
		compare_value("init_b_o", m_initb, init_b_o);
		compare_value("ntsc_o", m_ntsc, ntsc_o);
		compare_value("turbochipram_o", chipset_cfg_i[4] && !ovl_i && cpu_cfg_i[2]
			&& cpu_custom_i && mem_cfg_i[1] && mem_cfg_i[0], turbochipram_o);
		compare_value("turbokick_o", !ovl_i && (cpu_cfg_i[3] || chipset_cfg_i[4]), turbokick_o);
		compare_value("mode_15khz_o", scan15khz_i ^ vgaswitch_i, mode_15khz_o);
		compare_value("memcfg_o", mem_cfg_i[5:0], memcfg_o);
	endtask

	// falling edge, outputs settled, inputs may change right after
	task automatic next_cycle();
		@(negedge clk);
		if (checking)
			check_outputs();
	endtask

	function automatic bit random_chance(int pct);
		return ($urandom % 100) < pct;
	endfunction

	task automatic report_timeout(string what);
		$display("timeout: %s", what);
		$display("Done: errors found");
		$fatal(1, "wait limit reached");
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		next_cycle();
		while (rst_o !== 1'b0) begin
			if (n == WAIT_LIMIT)
				report_timeout("rst_o stayed high after all reset requests cleared");
			sof_i = random_chance(40); // frame starts
			n++;
			next_cycle();
		end
	endtask

	task automatic wait_sound_start();
		int n;
		n = 0;
		disk_change_n_i = 1'b1;
		next_cycle();
		while (drv_snd_o !== 1'b1) begin
			if (n == WAIT_LIMIT)
				report_timeout("drv_snd_o never rose for a step with a disk inserted");
			step_n_i = random_chance(50);
			sol_i    = random_chance(50);
			n++;
			next_cycle();
		end
	endtask

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	initial begin
		void'($urandom(9949));
		reset = 1'b1;
		clk7_en_i = 1'b1;
		{rst_ext_i, kbd_rst_i, usr_rst_i, cpu_rst_i} = 4'b0000;
		cpu_reset_in_n_i = 1'b1;
		{step_n_i, sol_i, sof_i} = 3'b100;  // step idles high
		{vsync_n_i, hsync_n_i} = 2'b11;
		{disk_change_n_i, led_n_i, turbo_i} = 3'b110;
		{ovl_i, cpu_custom_i, scan15khz_i, vgaswitch_i} = 4'b1000;
		chipset_cfg_i = '0;
		cpu_cfg_i = '0;
		mem_cfg_i = '0;
		repeat (3) @(posedge clk); // three rising edges in reset
		@(negedge clk);
		reset = 1'b0;
		checking = 1'b1;

		test_name = "reset_seq";
		wait_reset_release();
		repeat (20) begin
			case ($urandom % 4)
				0: rst_ext_i = 1'b1;
				1: kbd_rst_i = 1'b1;
				2: usr_rst_i = 1'b1;
				default: cpu_reset_in_n_i = 1'b0;
			endcase
			cpu_rst_i = random_chance(30);
			repeat (1 + $urandom % 3) begin
				next_cycle();
				sof_i = random_chance(40);
			end
			{rst_ext_i, kbd_rst_i, usr_rst_i} = 3'b000;
			cpu_reset_in_n_i = 1'b1;
			wait_reset_release();
		end
		cpu_rst_i = 1'b0;

		test_name = "step_sound";
		repeat (8) begin
			disk_change_n_i = random_chance(60); // disk absent now and then
			repeat (300) begin
				next_cycle();
				step_n_i = random_chance(50);
				sol_i    = random_chance(40);
			end
		end
		wait_sound_start();

		test_name = "led_dim";
		repeat (1500) begin
			next_cycle();
			hsync_n_i = random_chance(80);
			led_n_i   = random_chance(60);
			if (random_chance(5))
				turbo_i = ~turbo_i;
		end

		test_name = "mcu_sync";
		repeat (1500) begin
			next_cycle();
			vsync_n_i = random_chance(50);
			clk7_en_i = random_chance(50);
		end

		test_name = "mode_logic";
		repeat (1500) begin
			next_cycle();
			chipset_cfg_i = glue_pkg::chipset_cfg_t'($urandom);
			cpu_cfg_i     = glue_pkg::cpu_cfg_t'($urandom);
			mem_cfg_i     = glue_pkg::mem_cfg_t'($urandom);
			{ovl_i, cpu_custom_i} = 2'($urandom);
			{scan15khz_i, vgaswitch_i} = 2'($urandom);
			clk7_en_i = random_chance(50);
			kbd_rst_i = random_chance(2); // occasional reboot relatches ntsc
			sof_i     = random_chance(40);
		end

		next_cycle();
		$display("Done: no errors");
		$finish;
	end

endmodule
